/* design/hdmiTx_macros.svh */
// ~~~~~~~~~~~~~~~~~~~~
// Raster constants describe 640x480 at 60 Hz only, all values fit in 10 bits
// ~~~~~~~~~~~~~~~~~~~~
`ifndef HDMITX_MACROS_SVH
`define HDMITX_MACROS_SVH

// Horizontal timing in pixel clocks, the sync pulse covers hSyncStart up to hSyncEnd-1
`define hTotal      10'd800
`define hActive     10'd640
`define hSyncStart  10'd656
`define hSyncEnd    10'd752

// Vertical timing in lines
`define vTotal      10'd525
`define vActive     10'd480
`define vSyncStart  10'd490
`define vSyncEnd    10'd492

// AXI4-Lite byte offsets, only address bits 3:0 are decoded
`define regCtrl     4'h0
`define regSolid    4'h4
`define regPolarity 4'h8
`define regFrames   4'hC

`endif

/* design/hdmiTxPkg.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Types shared by the video path and the register block
// ~~~~~~~~~~~~~~~~~~~~
package hdmiTxPkg;

   // Picture source selected through regCtrl bits 1:0
   // Code 3 is not named and paints the bars
   typedef enum logic [1:0] {
      patBars  = 2'd0,
      patArt   = 2'd1,
      patSolid = 2'd2
   } patternMode;

   // Control period during blanking
   // Bit 1 is vsync and bit 0 is hsync, as carried on the blue lane
   typedef enum logic [1:0] {
      ctrl00 = 2'b00,
      ctrl01 = 2'b01,
      ctrl10 = 2'b10,
      ctrl11 = 2'b11
   } ctrlPeriod;

   // One 10-bit TMDS character, bit 0 is the first bit on the wire
   typedef logic [9:0] tmdsWord;

   // The clock lane sends five ones and five zeros per pixel
   localparam tmdsWord clockWord = 10'b1111100000;

endpackage

/* design/tmdsLaneIf.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Three colour lane symbols with one shared valid, lane 0 is blue
// ~~~~~~~~~~~~~~~~~~~~
interface tmdsLaneIf;

   // Encoded characters, indexed by lane number
   hdmiTxPkg::tmdsWord sym [3];

   // High once the symbols stem from counter states after reset
   logic valid;

   modport encSide (output sym, output valid);

   modport outSide (input sym, input valid);

endinterface

/* design/hdmiTxRegs.sv */
// ~~~~~~~~~~~~~~~~~~~~
// AXI4-Lite slave without bursts or strobes, one access in flight per direction
// ~~~~~~~~~~~~~~~~~~~~
`include "hdmiTx_macros.svh"

module hdmiTxRegs (
   input  logic                   pixclk,
   input  logic                   arstN,
   input  logic [3:0]             awaddr,
   input  logic                   awvalid,
   output logic                   awready,
   input  logic [31:0]            wdata,
   input  logic                   wvalid,
   output logic                   wready,
   output logic [1:0]             bresp,
   output logic                   bvalid,
   input  logic                   bready,
   input  logic [3:0]             araddr,
   input  logic                   arvalid,
   output logic                   arready,
   output logic [31:0]            rdata,
   output logic [1:0]             rresp,
   output logic                   rvalid,
   input  logic                   rready,
   input  logic                   frameStart,
   output hdmiTxPkg::patternMode  mode,
   output logic [23:0]            solidRgb,
   output logic [3:0]             lanePolarity
);

   logic [31:0] frameCount;
   logic [31:0] readMux;

   // Every access completes without error
   assign bresp = 2'b00;
   assign rresp = 2'b00;

   // Write side
   // The ready pulse comes only when address and data are both present and no response waits
   always_ff @(posedge pixclk or negedge arstN) begin
      if (!arstN) begin
         awready      <= 1'b0;
         wready       <= 1'b0;
         bvalid       <= 1'b0;
         mode         <= hdmiTxPkg::patBars;
         solidRgb     <= 24'd0;
         lanePolarity <= 4'd0;
      end else begin
         awready <= awvalid && wvalid && !awready && !bvalid;
         wready  <= awvalid && wvalid && !awready && !bvalid;
         if (awready) begin
            // The handshake completes in this cycle, so the response follows next cycle
            bvalid <= 1'b1;
            case (awaddr)
               `regCtrl:     mode         <= hdmiTxPkg::patternMode'(wdata[1:0]);
               `regSolid:    solidRgb     <= wdata[23:0];
               `regPolarity: lanePolarity <= wdata[3:0];
               default: ;
            endcase
         end else if (bvalid && bready) begin
            bvalid <= 1'b0;
         end
      end
   end

   // Frame counter wraps silently and cannot be written
   always_ff @(posedge pixclk or negedge arstN) begin
      if (!arstN) begin
         frameCount <= 32'd0;
      end else if (frameStart) begin
         frameCount <= frameCount + 32'd1;
      end
   end

   // Readback mux, unmapped offsets give zero
   always_comb begin
      case (araddr)
         `regCtrl:     readMux = {30'd0, mode};
         `regSolid:    readMux = {8'd0, solidRgb};
         `regPolarity: readMux = {28'd0, lanePolarity};
         `regFrames:   readMux = frameCount;
         default:      readMux = 32'd0;
      endcase
   end

   // Read side mirrors the write side with a single address channel
   always_ff @(posedge pixclk or negedge arstN) begin
      if (!arstN) begin
         arready <= 1'b0;
         rvalid  <= 1'b0;
      end else begin
         arready <= arvalid && !arready && !rvalid;
         if (arready) begin
            rvalid <= 1'b1;
         end else if (rvalid && rready) begin
            rvalid <= 1'b0;
         end
      end
   end

   // Read data is captured with the address handshake and then held
   always_ff @(posedge pixclk) begin
      if (arready) begin
         rdata <= readMux;
      end
   end

endmodule

/* design/videoTiming.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Sync outputs are active high before encoding; all outputs lag the counters by one clock
// ~~~~~~~~~~~~~~~~~~~~
`include "hdmiTx_macros.svh"

module videoTiming (
   input  logic                   pixclk,
   input  logic                   arstN,
   input  hdmiTxPkg::patternMode  mode,
   input  logic [23:0]            solidRgb,
   output logic [23:0]            pixelRgb,
   output logic                   drawArea,
   output hdmiTxPkg::ctrlPeriod   ctrl,
   output logic                   frameStart
);

   logic [9:0]  hCount;
   logic [9:0]  vCount;
   logic        hSync;
   logic        vSync;
   logic [3:0]  barIdx;
   logic [7:0]  diagMask;
   logic [7:0]  blockMask;
   logic [7:0]  artRed;
   logic [7:0]  artGreen;
   logic [7:0]  artBlue;
   logic [23:0] paint;

   // Pixel counter runs every clock, line counter steps at the end of each line
   always_ff @(posedge pixclk or negedge arstN) begin
      if (!arstN) begin
         hCount <= 10'd0;
         vCount <= 10'd0;
      end else if (hCount == `hTotal - 10'd1) begin
         hCount <= 10'd0;
         vCount <= (vCount == `vTotal - 10'd1) ? 10'd0 : vCount + 10'd1;
      end else begin
         hCount <= hCount + 10'd1;
      end
   end

   assign hSync = (hCount >= `hSyncStart) && (hCount < `hSyncEnd);
   assign vSync = (vCount >= `vSyncStart) && (vCount < `vSyncEnd);

   // Eight bars of 80 pixels; the index runs past 7 in blanking, where it is never shown
   assign barIdx = 4'(hCount / 10'd80);

   // Art picture is a white diagonal over a checker and ramps with one blue block cut out
   assign diagMask  = {8{hCount[7:0] == vCount[7:0]}};
   assign blockMask = {8{(hCount[7:5] == 3'd2) && (vCount[7:5] == 3'd2)}};
   assign artRed    = ({hCount[5:0] & {6{vCount[4:3] == ~hCount[4:3]}}, 2'b00} | diagMask)
                      & ~blockMask;
   assign artGreen  = ((hCount[7:0] & {8{vCount[6]}}) | diagMask) & ~blockMask;
   assign artBlue   = vCount[7:0] | diagMask | blockMask;

   always_comb begin
      case (mode)
         hdmiTxPkg::patArt:   paint = {artRed, artGreen, artBlue};
         hdmiTxPkg::patSolid: paint = solidRgb;
         default:             paint = {{8{barIdx[2]}}, {8{barIdx[1]}}, {8{barIdx[0]}}};
      endcase
   end

   // Strobes for the encoders, registered against the current counter state
   always_ff @(posedge pixclk or negedge arstN) begin
      if (!arstN) begin
         drawArea   <= 1'b0;
         ctrl       <= hdmiTxPkg::ctrl00;
         frameStart <= 1'b0;
      end else begin
         drawArea   <= (hCount < `hActive) && (vCount < `vActive);
         ctrl       <= hdmiTxPkg::ctrlPeriod'({vSync, hSync});
         frameStart <= (hCount == 10'd0) && (vCount == 10'd0);
      end
   end

   // Pixel colour is only looked at inside the draw area
   always_ff @(posedge pixclk) begin
      pixelRgb <= paint;
   end

endmodule

/* design/tmdsEncoder.sv */
// ~~~~~~~~~~~~~~~~~~~~
// DVI 8b/10b video and control coding only, no guard bands or TERC4
// ~~~~~~~~~~~~~~~~~~~~
module tmdsEncoder (
   input  logic                  pixclk,
   input  logic                  arstN,
   input  logic [7:0]            videoData,
   input  hdmiTxPkg::ctrlPeriod  ctrl,
   input  logic                  drawArea,
   output hdmiTxPkg::tmdsWord    symbol
);

   logic [3:0]          dataOnes;
   logic                useXnor;
   logic [8:0]          qm;
   logic [3:0]          qmOnes;
   logic signed [5:0]   qmBias;
   logic signed [5:0]   disparity;
   logic signed [5:0]   nextDisparity;
   hdmiTxPkg::tmdsWord  videoSym;
   hdmiTxPkg::tmdsWord  ctrlSym;

   // Stage one picks XOR or XNOR chaining to cut the number of transitions
   always_comb begin
      dataOnes = 4'd0;
      for (int i = 0; i < 8; i++) begin
         dataOnes = dataOnes + 4'(videoData[i]);
      end
      useXnor = (dataOnes > 4'd4) || ((dataOnes == 4'd4) && !videoData[0]);
      qm[0] = videoData[0];
      for (int i = 1; i < 8; i++) begin
         qm[i] = useXnor ? ~(qm[i-1] ^ videoData[i]) : (qm[i-1] ^ videoData[i]);
      end
      qm[8] = !useXnor;
   end

   // Ones minus zeros of the chained byte, between -8 and +8
   always_comb begin
      qmOnes = 4'd0;
      for (int i = 0; i < 8; i++) begin
         qmOnes = qmOnes + 4'(qm[i]);
      end
      qmBias = $signed({1'b0, qmOnes, 1'b0}) - 6'sd8;
   end

   // Stage two inverts the byte when that pulls the running disparity towards zero
   always_comb begin
      if ((disparity == 6'sd0) || (qmBias == 6'sd0)) begin
         videoSym      = {~qm[8], qm[8], qm[8] ? qm[7:0] : ~qm[7:0]};
         nextDisparity = qm[8] ? disparity + qmBias : disparity - qmBias;
      end else if (((disparity > 0) && (qmBias > 0)) || ((disparity < 0) && (qmBias < 0))) begin
         videoSym      = {1'b1, qm[8], ~qm[7:0]};
         nextDisparity = disparity + (qm[8] ? 6'sd2 : 6'sd0) - qmBias;
      end else begin
         videoSym      = {1'b0, qm[8], qm[7:0]};
         nextDisparity = disparity - (qm[8] ? 6'sd0 : 6'sd2) + qmBias;
      end
   end

   // The four control characters have many transitions so the sink can find word edges
   always_comb begin
      case (ctrl)
         hdmiTxPkg::ctrl01: ctrlSym = 10'b0010101011;
         hdmiTxPkg::ctrl10: ctrlSym = 10'b0101010100;
         hdmiTxPkg::ctrl11: ctrlSym = 10'b1010101011;
         default:           ctrlSym = 10'b1101010100;
      endcase
   end

   // Blanking restarts the disparity at zero for the next active line
   always_ff @(posedge pixclk or negedge arstN) begin
      if (!arstN) begin
         symbol    <= '0;
         disparity <= 6'sd0;
      end else if (drawArea) begin
         symbol    <= videoSym;
         disparity <= nextDisparity;
      end else begin
         symbol    <= ctrlSym;
         disparity <= 6'sd0;
      end
   end

endmodule

/* design/tmdsLinkOut.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Outputs stay zero until the lane bundle turns valid; polarity bit 3 is the clock lane
// ~~~~~~~~~~~~~~~~~~~~
module tmdsLinkOut (
   input  logic                pixclk,
   input  logic                arstN,
   tmdsLaneIf.outSide          lanes,
   input  logic [3:0]          lanePolarity,
   output hdmiTxPkg::tmdsWord  lane0,
   output hdmiTxPkg::tmdsWord  lane1,
   output hdmiTxPkg::tmdsWord  lane2,
   output hdmiTxPkg::tmdsWord  laneClk,
   output logic                laneValid
);

   // Inversion fixes swapped P and N traces on the board
   always_ff @(posedge pixclk or negedge arstN) begin
      if (!arstN) begin
         lane0     <= '0;
         lane1     <= '0;
         lane2     <= '0;
         laneClk   <= '0;
         laneValid <= 1'b0;
      end else begin
         laneValid <= lanes.valid;
         if (lanes.valid) begin
            lane0   <= lanes.sym[0] ^ {10{lanePolarity[0]}};
            lane1   <= lanes.sym[1] ^ {10{lanePolarity[1]}};
            lane2   <= lanes.sym[2] ^ {10{lanePolarity[2]}};
            laneClk <= hdmiTxPkg::clockWord ^ {10{lanePolarity[3]}};
         end else begin
            lane0   <= '0;
            lane1   <= '0;
            lane2   <= '0;
            laneClk <= '0;
         end
      end
   end

endmodule

/* design/hdmiTx.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Parallel 10-bit lane words only; the serializer and pads sit outside this core
// ~~~~~~~~~~~~~~~~~~~~
module hdmiTx (
   input  logic                pixclk,
   input  logic                arstN,
   input  logic [3:0]          awaddr,
   input  logic                awvalid,
   output logic                awready,
   input  logic [31:0]         wdata,
   input  logic                wvalid,
   output logic                wready,
   output logic [1:0]          bresp,
   output logic                bvalid,
   input  logic                bready,
   input  logic [3:0]          araddr,
   input  logic                arvalid,
   output logic                arready,
   output logic [31:0]         rdata,
   output logic [1:0]          rresp,
   output logic                rvalid,
   input  logic                rready,
   output hdmiTxPkg::tmdsWord  lane0,
   output hdmiTxPkg::tmdsWord  lane1,
   output hdmiTxPkg::tmdsWord  lane2,
   output hdmiTxPkg::tmdsWord  laneClk,
   output logic                laneValid
);

   hdmiTxPkg::patternMode  mode;
   hdmiTxPkg::ctrlPeriod   ctrl;
   logic [23:0]            solidRgb;
   logic [23:0]            pixelRgb;
   logic [3:0]             lanePolarity;
   logic                   drawArea;
   logic                   frameStart;
   logic [1:0]             validPipe;

   tmdsLaneIf lanes ();

   hdmiTxRegs hdmiTxRegs_i (
      .pixclk, .arstN,
      .awaddr, .awvalid, .awready, .wdata, .wvalid, .wready,
      .bresp, .bvalid, .bready,
      .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
      .frameStart, .mode, .solidRgb, .lanePolarity
   );

   videoTiming videoTiming_i (
      .pixclk, .arstN, .mode, .solidRgb, .pixelRgb, .drawArea, .ctrl, .frameStart
   );

   // Lane 0 carries blue and the syncs, green and red only ever send ctrl00
   for (genvar g = 0; g < 3; g++) begin : genLane
      tmdsEncoder tmdsEncoder_i (
         .pixclk,
         .arstN,
         .videoData (pixelRgb[8*g +: 8]),
         .ctrl      ((g == 0) ? ctrl : hdmiTxPkg::ctrl00),
         .drawArea,
         .symbol    (lanes.sym[g])
      );
   end

   // Tracks the timing and encoder register stages so valid marks the first real symbol
   always_ff @(posedge pixclk or negedge arstN) begin
      if (!arstN) begin
         validPipe <= 2'b00;
      end else begin
         validPipe <= {validPipe[0], 1'b1};
      end
   end

   assign lanes.valid = validPipe[1];

   tmdsLinkOut tmdsLinkOut_i (
      .pixclk, .arstN, .lanes (lanes.outSide), .lanePolarity,
      .lane0, .lane1, .lane2, .laneClk, .laneValid
   );

endmodule

/* verif/hdmiTx_chk.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Bound into hdmiTx, needs simulation with assertions enabled
// ~~~~~~~~~~~~~~~~~~~~
module hdmiTx_chk (
   input logic pixclk,
   input logic arstN,
   input logic laneValid,
   input logic bvalid,
   input logic bready,
   input logic rvalid,
   input logic rready,
   input logic frameStart
);
   timeunit 1ns;
   timeprecision 100ps;

   // Once the pipeline has filled the lanes never go invalid again
   validStays: assert property (@(posedge pixclk) disable iff (!arstN) laneValid |=> laneValid)
      else $error("laneValid fell after it had risen");

   // Responses wait for the master
   writeRespHolds: assert property (@(posedge pixclk) disable iff (!arstN)
      bvalid && !bready |=> bvalid) else $error("bvalid dropped before bready");
   readRespHolds: assert property (@(posedge pixclk) disable iff (!arstN)
      rvalid && !rready |=> rvalid) else $error("rvalid dropped before rready");

   frameStartPulse: assert property (@(posedge pixclk) disable iff (!arstN)
      frameStart |=> !frameStart) else $error("frameStart wider than one cycle");

endmodule

bind hdmiTx hdmiTx_chk hdmiTx_chk_i (
   .pixclk(pixclk), .arstN(arstN), .laneValid(laneValid), .bvalid(bvalid),
   .bready(bready), .rvalid(rvalid), .rready(rready), .frameStart(frameStart)
);

/* verif/hdmiTxTb.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Runs a little over two frames; the model lags the counters by the fixed 3 stages
// ~~~~~~~~~~~~~~~~~~~~
`include "hdmiTx_macros.svh"

module hdmiTxTb;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int hTot = int'(`hTotal);
   localparam int hAct = int'(`hActive);
   localparam int hsA = int'(`hSyncStart);
   localparam int hsB = int'(`hSyncEnd);
   localparam int vTot = int'(`vTotal);
   localparam int vAct = int'(`vActive);
   localparam int vsA = int'(`vSyncStart);
   localparam int vsB = int'(`vSyncEnd);
   // Two frames, some lines of margin and the register accesses at 30 cycles each
   localparam int limitNs = 2 * hTot * vTot * 4 + 64 * hTot * 4 + 60 * 30 * 4;
   // Clock lane carries five ones then five zeros
   localparam hdmiTxPkg::tmdsWord clkPattern = 10'b1111100000;

   logic pixclk, arstN, awvalid, wvalid, bready, arvalid, rready;
   logic awready, wready, bvalid, arready, rvalid, laneValid;
   logic [3:0] awaddr, araddr;
   logic [31:0] wdata, rdata;
   logic [1:0] bresp, rresp;
   hdmiTxPkg::tmdsWord lane0, lane1, lane2, laneClk;

   int errors, checks, testsRun, testsFailed, mh, mv, frames;
   int disp [3];
   bit checkOn;
   logic [31:0] rngState;
   hdmiTxPkg::patternMode mMode;
   logic [23:0] mSolid;
   logic [3:0] mPol;
   // Expected words packed as lane 2, lane 1, lane 0
   logic [29:0] expQ [$];

   always #2 pixclk = ~pixclk;

   hdmiTx hdmiTx_i (.*);

   function automatic logic [31:0] xorshift();
      rngState = rngState ^ (rngState << 13);
      rngState = rngState ^ (rngState >> 17);
      rngState = rngState ^ (rngState << 5);
      return rngState;
   endfunction

   // DVI encoding written from the spec rules, with the running disparity kept per lane
   function automatic hdmiTxPkg::tmdsWord encode(int lane, logic [7:0] d, bit draw,
                                                  logic [1:0] c);
      logic [8:0] q;
      bit xnorMode;
      int nq;
      hdmiTxPkg::tmdsWord w;
      if (!draw) begin
         disp[lane] = 0;
         case (c)
            2'b00: return 10'b1101010100;
            2'b01: return 10'b0010101011;
            2'b10: return 10'b0101010100;
            default: return 10'b1010101011;
         endcase
      end
      xnorMode = ($countones(d) > 4) || ($countones(d) == 4 && d[0] == 1'b0);
      q[0] = d[0];
      for (int i = 1; i < 8; i++) q[i] = xnorMode ? (q[i-1] ~^ d[i]) : (q[i-1] ^ d[i]);
      q[8] = !xnorMode;
      nq = $countones(q[7:0]);
      if (disp[lane] == 0 || nq == 4) begin
         w = {~q[8], q[8], q[8] ? q[7:0] : ~q[7:0]};
         disp[lane] += q[8] ? 2 * nq - 8 : 8 - 2 * nq;
      end else if ((disp[lane] > 0 && nq > 4) || (disp[lane] < 0 && nq < 4)) begin
         w = {1'b1, q[8], ~q[7:0]};
         disp[lane] += (q[8] ? 2 : 0) + 8 - 2 * nq;
      end else begin
         w = {1'b0, q[8], q[7:0]};
         disp[lane] += (q[8] ? 0 : -2) + 2 * nq - 8;
      end
      return w;
   endfunction

   // Picture formulas per mode, red in the top byte
   function automatic logic [23:0] paintModel(int h, int v);
      logic [7:0] diag, r, g, b;
      bit block;
      int bar;
      diag = (h % 256 == v % 256) ? 8'hFF : 8'h00;
      block = ((h / 32) % 8 == 2) && ((v / 32) % 8 == 2);
      r = (((v >> 3) & 3) == ((~h >> 3) & 3)) ? 8'((h & 63) << 2) : 8'h00;
      r = block ? 8'h00 : (r | diag);
      g = block ? 8'h00 : ((((v >> 6) & 1) == 1 ? 8'(h & 255) : 8'h00) | diag);
      b = block ? 8'hFF : (8'(v & 255) | diag);
      bar = h / 80;
      case (mMode)
         hdmiTxPkg::patArt: return {r, g, b};
         hdmiTxPkg::patSolid: return mSolid;
         default: return {{8{bar[2]}}, {8{bar[1]}}, {8{bar[0]}}};
      endcase
   endfunction

   task automatic checkWord(hdmiTxPkg::tmdsWord got, hdmiTxPkg::tmdsWord exp, string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("[ERROR] %0d ns: %s is %b, expected %b", $time, what, got, exp);
      end
   endtask

   task automatic checkData(logic [31:0] got, logic [31:0] exp, string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("[ERROR] %0d ns: %s is %h, expected %h", $time, what, got, exp);
      end
   endtask

   task automatic checkResp(logic [1:0] got, logic [1:0] exp, string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("[ERROR] %0d ns: %s is %b, expected %b", $time, what, got, exp);
      end
   endtask

   // Model sees counter state n at negedge n and compares the words of state n-3
   always @(negedge pixclk) begin : model
      logic [23:0] rgb;
      logic [29:0] old;
      logic [1:0] sync;
      bit draw;
      if (arstN) begin
         draw = mh < hAct && mv < vAct;
         rgb = paintModel(mh, mv);
         sync = {mv >= vsA && mv < vsB, mh >= hsA && mh < hsB};
         if (mh == 0 && mv == 0) frames++;
         expQ.push_back({encode(2, rgb[23:16], draw, 2'b00),
                         encode(1, rgb[15:8], draw, 2'b00),
                         encode(0, rgb[7:0], draw, sync)});
         if (expQ.size() > 3) begin
            old = expQ.pop_front();
            if (checkOn) begin
               checkData({31'd0, laneValid}, 32'd1, "laneValid");
               checkWord(lane0, old[9:0] ^ {10{mPol[0]}}, "lane0");
               checkWord(lane1, old[19:10] ^ {10{mPol[1]}}, "lane1");
               checkWord(lane2, old[29:20] ^ {10{mPol[2]}}, "lane2");
               checkWord(laneClk, clkPattern ^ {10{mPol[3]}}, "laneClk");
            end
         end
         mv = (mh == hTot - 1) ? ((mv == vTot - 1) ? 0 : mv + 1) : mv;
         mh = (mh == hTot - 1) ? 0 : mh + 1;
      end
   end

   // The master holds bready low for a few cycles so the response must wait
   task automatic axiWrite(logic [3:0] a, logic [31:0] d);
      int stall;
      stall = int'(xorshift() % 4);
      @(posedge pixclk);
      awaddr <= a;
      wdata <= d;
      awvalid <= 1'b1;
      wvalid <= 1'b1;
      @(negedge pixclk);
      while (!awready) @(negedge pixclk);
      @(posedge pixclk);
      awvalid <= 1'b0;
      wvalid <= 1'b0;
      @(negedge pixclk);
      while (!bvalid) @(negedge pixclk);
      checkResp(bresp, 2'b00, "write response");
      repeat (stall) @(posedge pixclk);
      @(posedge pixclk);
      bready <= 1'b1;
      @(posedge pixclk);
      bready <= 1'b0;
   endtask

   // Read data is taken just before the handshake, after the stall
   task automatic axiRead(logic [3:0] a, output logic [31:0] d);
      int stall;
      stall = int'(xorshift() % 4);
      @(posedge pixclk);
      araddr <= a;
      arvalid <= 1'b1;
      @(negedge pixclk);
      while (!arready) @(negedge pixclk);
      @(posedge pixclk);
      arvalid <= 1'b0;
      @(negedge pixclk);
      while (!rvalid) @(negedge pixclk);
      checkResp(rresp, 2'b00, "read response");
      repeat (stall) @(posedge pixclk);
      @(posedge pixclk);
      rready <= 1'b1;
      @(negedge pixclk);
      d = rdata;
      @(posedge pixclk);
      rready <= 1'b0;
   endtask

   // Writes all settings, then starts checking from the next blanking when both disparities are zero
   task automatic configure(logic [1:0] m, logic [23:0] solid, logic [3:0] pol);
      checkOn = 1'b0;
      mMode = hdmiTxPkg::patternMode'(m);
      mSolid = solid;
      mPol = pol;
      axiWrite(`regCtrl, {30'd0, m});
      axiWrite(`regSolid, {8'd0, solid});
      axiWrite(`regPolarity, {28'd0, pol});
      @(posedge pixclk);
      while (mh != hAct + 4) @(posedge pixclk);
      checkOn = 1'b1;
   endtask

   task automatic runLines(int n);
      repeat (n) begin
         @(posedge pixclk);
         while (mh != 0) @(posedge pixclk);
      end
      checkOn = 1'b0;
   endtask

   task automatic endTest(string name, int errBefore);
      testsRun++;
      if (errors > errBefore) testsFailed++;
      $display("test %s: %0d errors", name, errors - errBefore);
   endtask

   initial begin : watchdog
      #(limitNs);
      $display("watchdog: the tests did not finish within %0d ns", limitNs);
      $display("** FAIL **");
      $finish;
   end

   initial begin : main
      logic [31:0] d, rd;
      logic [3:0] a;
      int e0;
      pixclk = 1'b0;
      arstN = 1'b0;
      awvalid = 1'b0;
      wvalid = 1'b0;
      arvalid = 1'b0;
      bready = 1'b0;
      rready = 1'b0;
      awaddr = '0;
      araddr = '0;
      wdata = '0;
      rngState = 32'h1f7b_2a5a;
      mMode = hdmiTxPkg::patBars;
      mSolid = '0;
      mPol = '0;
      mh = 0;
      mv = 0;
      frames = 0;
      disp = '{0, 0, 0};
      checkOn = 1'b0;
      repeat (2) @(posedge pixclk);
      arstN <= 1'b1;

      e0 = errors;
      repeat (12) begin
         a = 4'((xorshift() % 3) * 4);
         d = xorshift();
         axiWrite(a, d);
         axiRead(a, rd);
         checkData(rd, d & ((a == `regCtrl) ? 32'h3 : (a == `regSolid) ? 32'hFF_FFFF : 32'hF),
                   "register readback");
      end
      axiWrite(`regFrames, xorshift());
      axiRead(`regFrames, rd);
      checkData(rd, 32'(frames), "frame counter after write");
      a = 4'((xorshift() % 4) * 4 + 1 + xorshift() % 3);
      axiRead(a, rd);
      checkData(rd, 32'd0, "unmapped offset");
      endTest("register access", e0);

      e0 = errors;
      for (int m = 0; m < 3; m++) begin
         configure(2'(m), 24'(xorshift()), 4'd0);
         runLines(3);
      end
      endTest("pattern and encoding", e0);

      // Vertical blanking holds both hsync and vsync combinations
      e0 = errors;
      @(posedge pixclk);
      while (mv != vAct - 2) @(posedge pixclk);
      checkOn = 1'b1;
      while (mv != vsB + 3) @(posedge pixclk);
      checkOn = 1'b0;
      endTest("sync symbols", e0);

      e0 = errors;
      configure(2'(xorshift() % 3), 24'(xorshift()), 4'(xorshift() % 15 + 1));
      runLines(2);
      endTest("polarity inversion", e0);

      e0 = errors;
      @(posedge pixclk);
      while (!(frames == 3 && mv == 20)) @(posedge pixclk);
      axiRead(`regFrames, rd);
      checkData(rd, 32'(frames), "frame count");
      endTest("frame count", e0);

      $display("tests %0d, failed %0d, checks %0d, errors %0d",
               testsRun, testsFailed, checks, errors);
      if (testsFailed == 0 && errors == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule

/* compile.f */
+incdir+design
design/hdmiTxPkg.sv
design/tmdsLaneIf.sv
design/hdmiTxRegs.sv
design/videoTiming.sv
design/tmdsEncoder.sv
design/tmdsLinkOut.sv
design/hdmiTx.sv
verif/hdmiTx_chk.sv
verif/hdmiTxTb.sv

/* run.sh */
#!/bin/sh
# Build and run with Verilator; the log decides pass or fail
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -j 0 --top-module hdmiTxTb -f compile.f -o simv > build.log 2>&1 \
   && ./obj_dir/simv > sim.log 2>&1 \
   || { echo "build or simulation failed, see build.log and sim.log"; exit 1; }
grep -F -q "** FAIL **" sim.log && { echo "simulation reported failure"; exit 1; }
grep -F -q "** PASS **" sim.log || { echo "no pass message in sim.log"; exit 1; }
echo "simulation passed"
